/* logic/xsecure_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy instruction insertion shared definitions
// Widths, encodings, CSR map, LFSR settings and bus types
// ~~~~~~~~~~~~~~~~~~~~

package xsecure_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  freq_t;

  localparam int NUM_LFSR = 3;

  // RV32 base opcodes used by the dummy instructions
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  // AND is encoded with the same funct7 as ADD
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  localparam csr_addr_t CSR_CPUCTRL     = 12'hBF0;
  localparam csr_addr_t CSR_SECURESEED0 = 12'hBF9;
  localparam csr_addr_t CSR_SECURESEED1 = 12'hBFA;
  localparam csr_addr_t CSR_SECURESEED2 = 12'hBFC;

  localparam reg_addr_t REG_X0 = 5'd0;

  // Right-shifting Galois feedback mask, bit 31 closes the loop
  localparam xlen_t LFSR_TAPS = 32'h8000_0057;
  localparam xlen_t LFSR_DEFAULT_SEED [NUM_LFSR] = '{
    32'hAC3B_91E5,
    32'h5E2D_07C1,
    32'h9F13_64A7
  };

  localparam int CPUCTRL_DUMMY_EN_BIT = 2;
  localparam int CPUCTRL_FREQ_LSB     = 16;

  typedef struct packed {
    logic  enable;
    freq_t freq;
  } dummy_cfg_t;

  typedef struct packed {
    logic  we;
    xlen_t value;
  } seed_wr_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  // One instruction word, read as register-register or as branch
  typedef union packed {
    r_type_t r;
    b_type_t b;
  } instr_word_u;

  typedef struct packed {
    logic        valid;
    logic        dummy;
    instr_word_u instr;
    xlen_t       operand_a;
    xlen_t       operand_b;
  } issue_t;

  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_op_e;

endpackage

/* logic/seed_csr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Secure CSR decode
// Holds the dummy configuration and turns seed CSR writes
// into per-LFSR load strobes
// ~~~~~~~~~~~~~~~~~~~~

module seed_csr_decode #(
  parameter int NUM_LFSR = xsecure_pkg::NUM_LFSR
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    csr_we,
  input  xsecure_pkg::csr_addr_t  csr_addr,
  input  xsecure_pkg::xlen_t      csr_wdata,
  output xsecure_pkg::dummy_cfg_t dummy_cfg,
  output xsecure_pkg::seed_wr_t   seed_wr [NUM_LFSR]
);

  // The seed registers are not contiguous in the CSR map
  localparam xsecure_pkg::csr_addr_t SEED_ADDR [xsecure_pkg::NUM_LFSR] = '{
    xsecure_pkg::CSR_SECURESEED0,
    xsecure_pkg::CSR_SECURESEED1,
    xsecure_pkg::CSR_SECURESEED2
  };

  logic cpuctrl_we;

  assign cpuctrl_we = csr_we && (csr_addr == xsecure_pkg::CSR_CPUCTRL);

  // Only the dummy enable and frequency fields of CPUCTRL live here
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      dummy_cfg <= '0;
    end else if (cpuctrl_we) begin
      dummy_cfg.enable <= csr_wdata[xsecure_pkg::CPUCTRL_DUMMY_EN_BIT];
      dummy_cfg.freq   <= csr_wdata[xsecure_pkg::CPUCTRL_FREQ_LSB +: $bits(xsecure_pkg::freq_t)];
    end
  end

  // A seed write reaches its LFSR in the same cycle as the CSR strobe
  for (genvar n = 0; n < NUM_LFSR; n++) begin : g_seed
    assign seed_wr[n] = '{
      we:    csr_we && (csr_addr == SEED_ADDR[n]),
      value: csr_wdata
    };
  end

endmodule

/* logic/lfsr_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// LFSR unit
// 32-bit Galois LFSR with seed load and lockup recovery
// ~~~~~~~~~~~~~~~~~~~~

module lfsr_unit #(
  parameter xsecure_pkg::xlen_t DEFAULT_SEED = 32'h0000_0001
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  xsecure_pkg::seed_wr_t seed_wr,
  input  logic                  step,
  output xsecure_pkg::xlen_t    state
);

  xsecure_pkg::xlen_t step_value;
  xsecure_pkg::xlen_t load_value;
  logic               lockup;
  logic               update;

  // Shift right and fold the taps back in when a one falls out
  always_comb begin
    step_value = state >> 1;
    if (state[0]) begin
      step_value = step_value ^ xsecure_pkg::LFSR_TAPS;
    end
  end

  // A software seed wins over a step in the same cycle
  assign load_value = seed_wr.we ? seed_wr.value : step_value;
  assign update     = seed_wr.we || step;

  // An all-zero state would never leave zero again
  assign lockup = (load_value == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state <= DEFAULT_SEED;
    end else if (update) begin
      if (lockup) begin
        state <= DEFAULT_SEED;
      end else begin
        state <= load_value;
      end
    end
  end

endmodule

/* logic/dummy_instr_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy instruction builder
// Forms a random ADD, AND, MUL or BLTU with its operands
// from the current LFSR states
// ~~~~~~~~~~~~~~~~~~~~

module dummy_instr_builder (
  input  xsecure_pkg::xlen_t  lfsr_state [xsecure_pkg::NUM_LFSR],
  output xsecure_pkg::issue_t dummy_issue
);

  xsecure_pkg::dummy_op_e   op;
  xsecure_pkg::reg_addr_t   rs1;
  xsecure_pkg::reg_addr_t   rs2;
  xsecure_pkg::instr_word_u instr;
  xsecure_pkg::xlen_t       operand_a;
  xsecure_pkg::xlen_t       operand_b;

  // LFSR0 picks the operation and both source registers
  assign op  = xsecure_pkg::dummy_op_e'(lfsr_state[0][1:0]);
  assign rs1 = lfsr_state[0][6:2];
  assign rs2 = lfsr_state[0][11:7];

  always_comb begin
    instr = '0;
    if (op == xsecure_pkg::DUMMY_BLTU) begin
      // Zero offset, so taken or not the branch lands on itself
      // and fetch carries on with the next real instruction
      instr.b.imm12   = 1'b0;
      instr.b.imm10_5 = '0;
      instr.b.rs2     = rs2;
      instr.b.rs1     = rs1;
      instr.b.funct3  = xsecure_pkg::FUNCT3_BLTU;
      instr.b.imm4_1  = '0;
      instr.b.imm11   = 1'b0;
      instr.b.opcode  = xsecure_pkg::OPCODE_BRANCH;
    end else begin
      instr.r.rs2    = rs2;
      instr.r.rs1    = rs1;
      instr.r.rd     = xsecure_pkg::REG_X0;
      instr.r.opcode = xsecure_pkg::OPCODE_OP;
      case (op)
        xsecure_pkg::DUMMY_AND: begin
          instr.r.funct7 = xsecure_pkg::FUNCT7_ADD;
          instr.r.funct3 = xsecure_pkg::FUNCT3_AND;
        end
        xsecure_pkg::DUMMY_MUL: begin
          instr.r.funct7 = xsecure_pkg::FUNCT7_MUL;
          instr.r.funct3 = xsecure_pkg::FUNCT3_MUL;
        end
        default: begin
          instr.r.funct7 = xsecure_pkg::FUNCT7_ADD;
          instr.r.funct3 = xsecure_pkg::FUNCT3_ADD;
        end
      endcase
    end
  end

  // x0 always reads zero, so the random data is dropped there
  always_comb begin
    operand_a = lfsr_state[1];
    operand_b = lfsr_state[2];
    if (rs1 == xsecure_pkg::REG_X0) begin
      operand_a = '0;
    end
    if (rs2 == xsecure_pkg::REG_X0) begin
      operand_b = '0;
    end
  end

  always_comb begin
    dummy_issue.valid     = 1'b1;
    dummy_issue.dummy     = 1'b1;
    dummy_issue.instr     = instr;
    dummy_issue.operand_a = operand_a;
    dummy_issue.operand_b = operand_b;
  end

endmodule

/* logic/dummy_insert_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy insertion control
// Counts issued instructions and merges dummies into the
// issue register ahead of the fetch stream
// ~~~~~~~~~~~~~~~~~~~~

module dummy_insert_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  xsecure_pkg::dummy_cfg_t dummy_cfg,
  input  logic                    allow_dummy,
  input  logic                    fetch_valid,
  input  xsecure_pkg::xlen_t      fetch_instr,
  input  logic                    issue_ready,
  input  xsecure_pkg::issue_t     dummy_issue,
  output logic                    fetch_ready,
  output logic                    lfsr_step,
  output xsecure_pkg::issue_t     issue
);

  logic [6:0]          interval;
  logic [6:0]          instr_count;
  logic                dummy_due;
  logic                insert_dummy;
  logic                fetch_fire;
  logic                issue_valid_q;
  xsecure_pkg::issue_t issue_next;
  xsecure_pkg::issue_t issue_q;

  // Frequency bands double the interval from 4 up to 64
  always_comb begin
    if (dummy_cfg.freq[3]) begin
      interval = 7'd64;
    end else if (dummy_cfg.freq[2]) begin
      interval = 7'd32;
    end else if (dummy_cfg.freq[1]) begin
      interval = 7'd16;
    end else if (dummy_cfg.freq[0]) begin
      interval = 7'd8;
    end else begin
      interval = 7'd4;
    end
  end

  assign dummy_due    = dummy_cfg.enable && allow_dummy && (instr_count >= interval);
  assign insert_dummy = dummy_due && issue_ready;
  assign fetch_ready  = issue_ready && !dummy_due;
  assign fetch_fire   = fetch_valid && fetch_ready;
  assign lfsr_step    = insert_dummy;

  // Saturates so a long allow_dummy gap cannot wrap the count
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_count <= '0;
    end else if (!dummy_cfg.enable || insert_dummy) begin
      instr_count <= '0;
    end else if (fetch_fire && (instr_count != '1)) begin
      instr_count <= instr_count + 7'd1;
    end
  end

  always_comb begin
    issue_next           = '0;
    issue_next.instr     = fetch_instr;
    if (insert_dummy) begin
      issue_next = dummy_issue;
    end else if (fetch_fire) begin
      issue_next.valid = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      issue_valid_q <= 1'b0;
    end else if (issue_ready) begin
      issue_valid_q <= issue_next.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_ready) begin
      issue_q <= issue_next;
    end
  end

  always_comb begin
    issue       = issue_q;
    issue.valid = issue_valid_q;
  end

endmodule

/* logic/dummy_insert_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy insertion top
// Connects CSR decode, the LFSR bank, the builder and the
// issue control
// ~~~~~~~~~~~~~~~~~~~~

module dummy_insert_top #(
  parameter int NUM_LFSR = xsecure_pkg::NUM_LFSR
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   csr_we,
  input  xsecure_pkg::csr_addr_t csr_addr,
  input  xsecure_pkg::xlen_t     csr_wdata,
  input  logic                   allow_dummy,
  input  logic                   fetch_valid,
  input  xsecure_pkg::xlen_t     fetch_instr,
  input  logic                   issue_ready,
  output logic                   fetch_ready,
  output xsecure_pkg::issue_t    issue
);

  xsecure_pkg::dummy_cfg_t dummy_cfg;
  xsecure_pkg::seed_wr_t   seed_wr [NUM_LFSR];
  xsecure_pkg::xlen_t      lfsr_state [NUM_LFSR];
  xsecure_pkg::issue_t     dummy_issue;
  logic                    lfsr_step;

  seed_csr_decode #(
    .NUM_LFSR (NUM_LFSR)
  ) u_seed_csr_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .dummy_cfg (dummy_cfg),
    .seed_wr   (seed_wr)
  );

  // All LFSRs step together, each from its own default seed
  for (genvar g = 0; g < NUM_LFSR; g++) begin : g_lfsr
    lfsr_unit #(
      .DEFAULT_SEED (xsecure_pkg::LFSR_DEFAULT_SEED[g])
    ) u_lfsr_unit (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .seed_wr (seed_wr[g]),
      .step    (lfsr_step),
      .state   (lfsr_state[g])
    );
  end

  dummy_instr_builder u_dummy_instr_builder (
    .lfsr_state  (lfsr_state),
    .dummy_issue (dummy_issue)
  );

  dummy_insert_ctrl u_dummy_insert_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dummy_cfg   (dummy_cfg),
    .allow_dummy (allow_dummy),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .issue_ready (issue_ready),
    .dummy_issue (dummy_issue),
    .fetch_ready (fetch_ready),
    .lfsr_step   (lfsr_step),
    .issue       (issue)
  );

endmodule

/* dv/tb_dummy_insert.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Dummy insertion testbench
// Replays the vector file and checks every issued entry
// against a reference LFSR and interval model
// ~~~~~~~~~~~~~~~~~~~~

module tb_dummy_insert;

  localparam int WAIT_LIMIT = 64;
  localparam xsecure_pkg::csr_addr_t SEED_CSR [xsecure_pkg::NUM_LFSR] = '{
    xsecure_pkg::CSR_SECURESEED0,
    xsecure_pkg::CSR_SECURESEED1,
    xsecure_pkg::CSR_SECURESEED2
  };

  logic                   clk_i;
  logic                   rst_ni;
  logic                   csr_we;
  xsecure_pkg::csr_addr_t csr_addr;
  xsecure_pkg::xlen_t     csr_wdata;
  logic                   allow_dummy;
  logic                   fetch_valid;
  xsecure_pkg::xlen_t     fetch_instr;
  logic                   issue_ready;
  logic                   fetch_ready;
  xsecure_pkg::issue_t    issue;

  // Reference model state, updated as entries leave the DUT
  xsecure_pkg::xlen_t model_lfsr [xsecure_pkg::NUM_LFSR];
  logic               cfg_en;
  xsecure_pkg::freq_t cfg_freq;
  int                 normal_count;
  int unsigned        next_sent;
  int unsigned        next_expected;
  int                 dummies_seen;
  int                 normals_seen;
  int                 errors;
  logic               ready_q;
  logic               allow_q;
  logic               timed_out;
  int unsigned        rng_state;

  dummy_insert_top #(
    .NUM_LFSR (xsecure_pkg::NUM_LFSR)
  ) uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_we      (csr_we),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .allow_dummy (allow_dummy),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .issue_ready (issue_ready),
    .fetch_ready (fetch_ready),
    .issue       (issue)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  // Doubling bands: 0, 1, 2-3, 4-7, 8-15
  function automatic int interval_for(xsecure_pkg::freq_t freq);
    if (freq >= 4'd8) return 64;
    if (freq >= 4'd4) return 32;
    if (freq >= 4'd2) return 16;
    if (freq == 4'd1) return 8;
    return 4;
  endfunction

  function automatic xsecure_pkg::xlen_t instr_for(int unsigned number);
    return 32'h5A00_0000 + number;
  endfunction

  function automatic xsecure_pkg::xlen_t lfsr_advance(xsecure_pkg::xlen_t cur,
                                                      xsecure_pkg::xlen_t seed);
    xsecure_pkg::xlen_t nxt;
    nxt = {1'b0, cur[31:1]} ^ (cur[0] ? xsecure_pkg::LFSR_TAPS : 32'd0);
    return (nxt == 32'd0) ? seed : nxt;
  endfunction

  task automatic compare_field(string name, xsecure_pkg::xlen_t got, xsecure_pkg::xlen_t expected);
    if (got !== expected) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // Decodes the dummy through the view its operation selects
  task automatic check_dummy();
    xsecure_pkg::xlen_t     pick;
    xsecure_pkg::reg_addr_t rs1;
    xsecure_pkg::reg_addr_t rs2;
    logic [1:0]             op;
    logic [6:0]             f7;
    logic [2:0]             f3;
    pick = model_lfsr[0];
    op   = pick[1:0];
    rs1  = pick[6:2];
    rs2  = pick[11:7];
    if (op == 2'd3) begin
      compare_field("issue.instr.b.opcode", 32'(issue.instr.b.opcode),
                    32'(xsecure_pkg::OPCODE_BRANCH));
      compare_field("issue.instr.b.funct3", 32'(issue.instr.b.funct3),
                    32'(xsecure_pkg::FUNCT3_BLTU));
      compare_field("issue.instr.b.rs1", 32'(issue.instr.b.rs1), 32'(rs1));
      compare_field("issue.instr.b.rs2", 32'(issue.instr.b.rs2), 32'(rs2));
      compare_field("issue.instr.b.imm", 32'({issue.instr.b.imm12, issue.instr.b.imm11,
                    issue.instr.b.imm10_5, issue.instr.b.imm4_1}), 32'd0);
    end else begin
      f7 = (op == 2'd2) ? xsecure_pkg::FUNCT7_MUL : xsecure_pkg::FUNCT7_ADD;
      case (op)
        2'd0:    f3 = xsecure_pkg::FUNCT3_ADD;
        2'd1:    f3 = xsecure_pkg::FUNCT3_AND;
        default: f3 = xsecure_pkg::FUNCT3_MUL;
      endcase
      compare_field("issue.instr.r.opcode", 32'(issue.instr.r.opcode),
                    32'(xsecure_pkg::OPCODE_OP));
      compare_field("issue.instr.r.funct7", 32'(issue.instr.r.funct7), 32'(f7));
      compare_field("issue.instr.r.funct3", 32'(issue.instr.r.funct3), 32'(f3));
      compare_field("issue.instr.r.rd", 32'(issue.instr.r.rd), 32'd0);
      compare_field("issue.instr.r.rs1", 32'(issue.instr.r.rs1), 32'(rs1));
      compare_field("issue.instr.r.rs2", 32'(issue.instr.r.rs2), 32'(rs2));
    end
    compare_field("issue.operand_a", issue.operand_a, (rs1 == 5'd0) ? 32'd0 : model_lfsr[1]);
    compare_field("issue.operand_b", issue.operand_b, (rs2 == 5'd0) ? 32'd0 : model_lfsr[2]);
    for (int n = 0; n < xsecure_pkg::NUM_LFSR; n++) begin
      model_lfsr[n] = lfsr_advance(model_lfsr[n], xsecure_pkg::LFSR_DEFAULT_SEED[n]);
    end
  endtask

  // An entry counts once, at the edge after it was loaded with issue_ready high
  always @(negedge clk_i) begin
    if (rst_ni && ready_q && issue.valid) begin
      if (issue.dummy) begin
        if (!(cfg_en && allow_q && normal_count >= interval_for(cfg_freq))) begin
          $display("Dummy issued at t=%0t after only %0d normal instructions or while not allowed",
                   $time, normal_count);
          errors++;
        end
        check_dummy();
        normal_count = 0;
        dummies_seen++;
      end else begin
        if (cfg_en && allow_q && normal_count >= interval_for(cfg_freq)) begin
          $display("Normal instruction issued at t=%0t where a dummy was due", $time);
          errors++;
        end
        compare_field("issue.instr", 32'(issue.instr), instr_for(next_expected));
        next_expected++;
        normals_seen++;
        if (cfg_en) begin
          normal_count++;
        end
      end
    end
    ready_q = issue_ready;
    allow_q = allow_dummy;
  end

  task automatic write_csr(xsecure_pkg::csr_addr_t addr, xsecure_pkg::xlen_t data);
    issue_ready = 1'b0;
    fetch_valid = 1'b0;
    csr_we      = 1'b1;
    csr_addr    = addr;
    csr_wdata   = data;
    @(posedge clk_i);
    #2;
    csr_we = 1'b0;
    if (addr == xsecure_pkg::CSR_CPUCTRL) begin
      cfg_en   = data[xsecure_pkg::CPUCTRL_DUMMY_EN_BIT];
      cfg_freq = data[xsecure_pkg::CPUCTRL_FREQ_LSB +: 4];
      if (!cfg_en) begin
        normal_count = 0;
      end
    end
    for (int n = 0; n < xsecure_pkg::NUM_LFSR; n++) begin
      if (addr == SEED_CSR[n]) begin
        model_lfsr[n] = (data == 32'd0) ? xsecure_pkg::LFSR_DEFAULT_SEED[n] : data;
      end
    end
    issue_ready = 1'b1;
  endtask

  task automatic run_instrs(int count, logic stall, logic allow);
    int   sent;
    int   waited;
    logic accepted;
    logic idle;
    sent        = 0;
    waited      = 0;
    idle        = 1'b0;
    allow_dummy = allow;
    while (sent < count && !timed_out) begin
      fetch_valid = 1'b1;
      fetch_instr = instr_for(next_sent);
      issue_ready = stall ? ((lcg_next() % 4) != 0) : 1'b1;
      @(negedge clk_i);
      accepted = fetch_ready;
      @(posedge clk_i);
      #2;
      if (accepted) begin
        sent++;
        next_sent++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout at t=%0t: fetch_ready stayed low too long", $time);
          timed_out = 1'b1;
        end
      end
    end
    // Let a pending dummy go out before the next step
    fetch_valid = 1'b0;
    issue_ready = 1'b1;
    waited      = 0;
    while (!idle && !timed_out) begin
      @(negedge clk_i);
      idle = fetch_ready && !issue.valid;
      @(posedge clk_i);
      #2;
      if (!idle) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          $display("Timeout at t=%0t: issue stage never went idle", $time);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  initial begin
    int                 fd;
    int                 code;
    int                 base;
    logic [8*96-1:0]    line;
    logic [8*8-1:0]     op;
    int unsigned        f1;
    int unsigned        f2;
    int unsigned        f3;
    rst_ni        = 1'b0;
    csr_we        = 1'b0;
    csr_addr      = '0;
    csr_wdata     = '0;
    allow_dummy   = 1'b1;
    fetch_valid   = 1'b0;
    fetch_instr   = '0;
    issue_ready   = 1'b0;
    cfg_en        = 1'b0;
    cfg_freq      = '0;
    normal_count  = 0;
    next_sent     = 0;
    next_expected = 0;
    dummies_seen  = 0;
    normals_seen  = 0;
    errors        = 0;
    ready_q       = 1'b0;
    allow_q       = 1'b0;
    timed_out     = 1'b0;
    rng_state     = 52629;
    base          = 0;
    for (int n = 0; n < xsecure_pkg::NUM_LFSR; n++) begin
      model_lfsr[n] = xsecure_pkg::LFSR_DEFAULT_SEED[n];
    end
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni      = 1'b1;
    issue_ready = 1'b1;
    @(negedge clk_i);
    compare_field("issue.valid", 32'(issue.valid), 32'd0);
    compare_field("fetch_ready", 32'(fetch_ready), 32'(issue_ready));
    @(posedge clk_i);
    #2;
    fd = $fopen("dv/dummy_insert_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = '0;
        op   = '0;
        if ($fgets(line, fd) != 0 && $sscanf(line, "%s", op) == 1 && op != 64'("#")) begin
          if (op == 64'("csr")) begin
            code = $sscanf(line, "%s %h %h", op, f1, f2);
            if (code != 3) begin
              $display("Malformed csr line in the vector file");
              errors++;
            end else begin
              write_csr(f1[11:0], f2);
            end
          end else if (op == 64'("run")) begin
            code = $sscanf(line, "%s %d %d %d", op, f1, f2, f3);
            if (code != 4) begin
              $display("Malformed run line in the vector file");
              errors++;
            end else begin
              run_instrs(int'(f1), f2[0], f3[0]);
            end
          end else if (op == 64'("expect")) begin
            code = $sscanf(line, "%s %d", op, f1);
            if (code != 2) begin
              $display("Malformed expect line in the vector file");
              errors++;
            end else if (dummies_seen - base != int'(f1)) begin
              $display("FAIL t=%0t dummy_count got %0d expected %0d",
                       $time, dummies_seen - base, f1);
              errors++;
            end
            base = dummies_seen;
          end else begin
            $display("Unknown operation in the vector file: %0s", op);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    $display("Summary: %0d errors, %0d normal and %0d dummy instructions checked",
             errors, normals_seen, dummies_seen);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* dv/dummy_insert_vectors.txt */
# csr <addr hex> <data hex> | run <count> <stall 0/1> <allow 0/1> | expect <dummies>
# Counts are multiples of N, so dummies = count / N per band
run 12 0 1
expect 0
csr bf0 00000004
run 16 0 1
expect 4
run 20 1 1
expect 5
csr bf0 00010004
run 24 1 1
expect 3
csr bf0 00020004
run 32 1 1
expect 2
csr bf0 00030004
run 16 0 1
expect 1
csr bf0 00050004
run 64 1 1
expect 2
csr bf0 00090004
run 64 1 1
expect 1
# Back to N of 4, then seed the LFSRs, one seed is zero
csr bf0 00000004
csr bf9 12345678
csr bfa 0badf00d
csr bfc 00000000
run 16 1 1
expect 4
csr bfa 00000000
run 8 0 1
expect 2
# Held off while allow_dummy is low, then due at once
run 12 0 0
expect 0
run 4 0 1
expect 2
csr bf0 00000000
run 20 1 1
expect 0

/* list.f */
logic/xsecure_pkg.sv
logic/seed_csr_decode.sv
logic/lfsr_unit.sv
logic/dummy_instr_builder.sv
logic/dummy_insert_ctrl.sv
logic/dummy_insert_top.sv
dv/tb_dummy_insert.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the dummy insertion testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  --top-module tb_dummy_insert \
  -f list.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi
